// ==== common/rv_pkg.sv ====
package rv_pkg;

	parameter int unsigned xlen = 32;

	typedef enum logic [3:0]
	{
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;

	typedef enum logic [3:0]
	{
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	// writeback source select
	typedef enum logic [2:0] {WB_ALU, WB_PC4, WB_MUL, WB_LUI, WB_MEM, WB_AUIPC} wb_sel_e;

	typedef enum logic [1:0] {MODE_U = 2'd0, MODE_S = 2'd1, MODE_M = 2'd3} mode_e;

	// cause field without the interrupt bit
	parameter logic [xlen-2:0] I_ADDR_MISALIGNED = 31'd0;
	parameter logic [xlen-2:0] I_ILLEGAL         = 31'd2;
	parameter logic [xlen-2:0] L_ADDR_MISALIGNED = 31'd4;
	parameter logic [xlen-2:0] U_CALL            = 31'd8;   // plus mode gives S/M call
	parameter logic [xlen-2:0] S_INT_TIMER       = 31'd5;
	parameter logic [xlen-2:0] M_INT_TIMER       = 31'd7;
	parameter logic [xlen-2:0] S_INT_EXT         = 31'd9;
	parameter logic [xlen-2:0] M_INT_EXT         = 31'd11;

	typedef struct packed {
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;   // also I_imm for loads and jalr, store data for stores
		logic [xlen-1:0] pc;
		logic [xlen-1:0] b_imm;
		logic [xlen-1:0] j_imm;
		logic [xlen-1:0] u_imm;
		logic [xlen-1:0] s_imm;
		logic [4:0]      rd;
		logic            we;
		alu_op_e         alu_fn;
		wb_sel_e         wb_sel;
		mul_op_e         mul_op;
		mem_op_e         mem_op;
		logic            btype;
		logic            bneq;
		logic            j;
		logic            jr;
		logic            instr_misaligned;
		logic            ecall;
		logic            illegal;
	} exe_req_t;

	typedef struct packed {
		logic [xlen-1:0] data;
		logic [4:0]      rd;
		logic            we;
	} wb_t;

	typedef struct packed {
		logic m_timer;
		logic s_timer;
		logic m_ext;
		logic s_ext;
		logic m_tie;
		logic s_tie;
		logic m_eie;
		logic s_eie;
	} irq_t;

	typedef struct packed {
		logic            pending;
		logic [xlen-1:0] cause;   // msb set for interrupts
		logic [xlen-1:0] pc;
	} trap_t;

	typedef struct packed {
		logic instr_misaligned;
		logic ecall;
		logic illegal;
		logic mem_misaligned;
	} exc_t;

endpackage

// ==== exe_stage/alu.sv ====
module alu (
	input  rv_pkg::alu_op_e          alu_fn,
	input  logic [rv_pkg::xlen-1:0]  a,
	input  logic [rv_pkg::xlen-1:0]  b,
	input  logic                     btype,
	input  logic                     bneq,
	output logic [rv_pkg::xlen-1:0]  result,
	output logic                     btaken
);

	logic cond;

	always_comb
	begin
		unique case (alu_fn)
			rv_pkg::ALU_ADD:  result = a + b;
			rv_pkg::ALU_SUB:  result = a - b;
			rv_pkg::ALU_SLL:  result = a << b[4:0];
			rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			rv_pkg::ALU_SLTU: result = {31'b0, a < b};
			rv_pkg::ALU_XOR:  result = a ^ b;
			rv_pkg::ALU_SRL:  result = a >> b[4:0];
			rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> b[4:0]);
			rv_pkg::ALU_OR:   result = a | b;
			rv_pkg::ALU_AND:  result = a & b;
			default:          result = '0;
		endcase
	end

	// blt/bltu use the compare result, beq uses equality
	// bneq flips it, which also gives bne, bge and bgeu
	assign cond = (alu_fn == rv_pkg::ALU_SLT || alu_fn == rv_pkg::ALU_SLTU) ? result[0]
		: (a == b);
	assign btaken = btype & (cond ^ bneq);

endmodule

// ==== exe_stage/branch_unit.sv ====
module branch_unit (
	input  logic [rv_pkg::xlen-1:0] pc,
	input  logic [rv_pkg::xlen-1:0] a,
	input  logic [rv_pkg::xlen-1:0] b_imm,
	input  logic [rv_pkg::xlen-1:0] j_imm,
	input  logic [rv_pkg::xlen-1:0] i_imm,
	input  logic                    btaken,
	input  logic                    j,
	input  logic                    jr,
	output logic [rv_pkg::xlen-1:0] target,
	output logic                    taken
);

	logic [rv_pkg::xlen-1:0] jr_sum;

	assign jr_sum = a + i_imm;

	always_comb
	begin
		if (jr)
			target = {jr_sum[rv_pkg::xlen-1:1], 1'b0};   // jalr drops bit 0
		else if (j)
			target = pc + j_imm;
		else if (btaken)
			target = pc + b_imm;
		else
			target = pc + 32'd4;
	end

	assign taken = btaken | j | jr;

endmodule

// ==== exe_stage/mul_div.sv ====
module mul_div (
	input  rv_pkg::mul_op_e         op,
	input  logic [rv_pkg::xlen-1:0] a,
	input  logic [rv_pkg::xlen-1:0] b,
	output logic [rv_pkg::xlen-1:0] res
);

	logic               a_signed;
	logic               b_signed;
	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [65:0] prod;

	// mulhsu takes a as signed and b as unsigned
	assign a_signed = (op == rv_pkg::MUL_MULH) || (op == rv_pkg::MUL_MULHSU);
	assign b_signed = (op == rv_pkg::MUL_MULH);

	// one extra bit so a single signed multiply covers every variant
	assign a_ext = {a_signed & a[31], a};
	assign b_ext = {b_signed & b[31], b};
	assign prod  = a_ext * b_ext;

	always_comb
	begin
		if (op == rv_pkg::MUL_MUL)
			res = prod[31:0];
		else
			res = prod[63:32];   // high word
	end

endmodule

// ==== exe_stage/exe_stage.sv ====
module exe_stage (
	input  logic                    clk,
	input  logic                    nrst,
	input  rv_pkg::exe_req_t        req,
	input  logic                    squash,
	output logic [rv_pkg::xlen-1:0] mem_addr,
	output logic [rv_pkg::xlen-1:0] mem_wdata,
	output rv_pkg::mem_op_e         mem_op,
	input  logic [rv_pkg::xlen-1:0] mem_rdata,
	input  logic                    mem_misaligned,
	output rv_pkg::wb_t             wb,
	output logic [rv_pkg::xlen-1:0] target,
	output logic                    bj_taken,
	output rv_pkg::exc_t            exc,
	output logic [rv_pkg::xlen-1:0] pc6
);

	typedef struct packed {
		logic [rv_pkg::xlen-1:0] alu_res;
		logic [rv_pkg::xlen-1:0] mul_res;
		logic [rv_pkg::xlen-1:0] mem_data;
		logic [rv_pkg::xlen-1:0] u_imm;
		logic [rv_pkg::xlen-1:0] au_imm;
		logic [rv_pkg::xlen-1:0] pc;
		logic [4:0]              rd;
		logic                    we;
		rv_pkg::wb_sel_e         wb_sel;
		rv_pkg::exc_t            exc;
	} p6_t;

	rv_pkg::exe_req_t        p5;
	p6_t                     p6;
	logic [rv_pkg::xlen-1:0] alu_res5;
	logic [rv_pkg::xlen-1:0] mul_res5;
	logic                    btaken4;
	logic                    is_store;

	// taken flag straight from issue operands
	alu i_alu_issue (
		.alu_fn (req.alu_fn),
		.a      (req.op_a),
		.b      (req.op_b),
		.btype  (req.btype),
		.bneq   (req.bneq),
		.result (),
		.btaken (btaken4)
	);

	branch_unit i_branch_unit (
		.pc     (req.pc),
		.a      (req.op_a),
		.b_imm  (req.b_imm),
		.j_imm  (req.j_imm),
		.i_imm  (req.op_b),
		.btaken (btaken4),
		.j      (req.j),
		.jr     (req.jr),
		.target (target),
		.taken  (bj_taken)
	);

	// dmem registers the address taken from the issue request
	assign is_store  = req.mem_op inside {rv_pkg::MEM_SB, rv_pkg::MEM_SH, rv_pkg::MEM_SW};
	assign mem_addr  = req.op_a + (is_store ? req.s_imm : req.op_b);
	assign mem_wdata = req.op_b;
	assign mem_op    = req.mem_op;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			p5 <= '0;
		else
			p5 <= req;
	end

	alu i_alu (
		.alu_fn (p5.alu_fn),
		.a      (p5.op_a),
		.b      (p5.op_b),
		.btype  (1'b0),
		.bneq   (1'b0),
		.result (alu_res5),
		.btaken ()
	);

	mul_div i_mul_div (
		.op  (p5.mul_op),
		.a   (p5.op_a),
		.b   (p5.op_b),
		.res (mul_res5)
	);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			p6 <= '0;
		else if (squash)
			p6 <= '0;   // bubble while trap flushes
		else
		begin
			p6.alu_res  <= alu_res5;
			p6.mul_res  <= mul_res5;
			p6.mem_data <= mem_rdata;
			p6.u_imm    <= p5.u_imm;
			p6.au_imm   <= p5.u_imm + p5.pc;   // auipc
			p6.pc       <= p5.pc;
			p6.rd       <= p5.rd;
			p6.we       <= p5.we;
			p6.wb_sel   <= p5.wb_sel;
			p6.exc.instr_misaligned <= p5.instr_misaligned;
			p6.exc.ecall            <= p5.ecall;
			p6.exc.illegal          <= p5.illegal;
			p6.exc.mem_misaligned   <= mem_misaligned;
		end
	end

	always_comb
	begin
		unique case (p6.wb_sel)
			rv_pkg::WB_ALU:   wb.data = p6.alu_res;
			rv_pkg::WB_PC4:   wb.data = p6.pc + 32'd4;
			rv_pkg::WB_MUL:   wb.data = p6.mul_res;
			rv_pkg::WB_LUI:   wb.data = p6.u_imm;
			rv_pkg::WB_MEM:   wb.data = p6.mem_data;
			rv_pkg::WB_AUIPC: wb.data = p6.au_imm;
			default:          wb.data = '0;
		endcase
	end

	assign wb.rd = p6.rd;
	assign wb.we = p6.we;
	assign exc   = p6.exc;
	assign pc6   = p6.pc;

endmodule

// ==== verilog/dmem.sv ====
module dmem #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  rv_pkg::mem_op_e         op,
	input  logic [rv_pkg::xlen-1:0] addr,
	input  logic [rv_pkg::xlen-1:0] wdata,
	output logic [rv_pkg::xlen-1:0] rdata,
	output logic                    misaligned
);

	localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

	logic [rv_pkg::xlen-1:0] mem [DMEM_WORDS];
	logic [AW-1:0]           idx;
	logic [3:0]              be;
	logic [rv_pkg::xlen-1:0] wlanes;
	logic                    is_half;
	logic                    is_word;
	logic                    mis;
	logic [rv_pkg::xlen-1:0] rword;
	logic [rv_pkg::xlen-1:0] shifted;
	logic [1:0]              roff;
	rv_pkg::mem_op_e         rop;

	assign idx = AW'((addr >> 2) % DMEM_WORDS);

	assign is_half = op inside {rv_pkg::MEM_LH, rv_pkg::MEM_LHU, rv_pkg::MEM_SH};
	assign is_word = op inside {rv_pkg::MEM_LW, rv_pkg::MEM_SW};
	assign mis     = (is_half && addr[0]) || (is_word && addr[1:0] != 2'b00);

	// store data replicated over all lanes with be picking the written ones
	always_comb
	begin
		be     = 4'b0000;
		wlanes = wdata;
		case (op)
			rv_pkg::MEM_SB:
			begin
				be     = 4'b0001 << addr[1:0];
				wlanes = {4{wdata[7:0]}};
			end
			rv_pkg::MEM_SH:
			begin
				be     = 4'b0011 << addr[1:0];
				wlanes = {2{wdata[15:0]}};
			end
			rv_pkg::MEM_SW: be = 4'b1111;
			default:        be = 4'b0000;
		endcase
		if (mis)
			be = 4'b0000;   // misaligned store is dropped
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
			rword      <= '0;
			roff       <= 2'b00;
			rop        <= rv_pkg::MEM_NONE;
			misaligned <= 1'b0;
		end
		else
		begin
			for (int k = 0; k < 4; k++)
				if (be[k])
					mem[idx][8*k +: 8] <= wlanes[8*k +: 8];
			rword      <= mem[idx];   // word as it was before this edge
			roff       <= addr[1:0];
			rop        <= op;
			misaligned <= mis;
		end
	end

	assign shifted = rword >> {roff, 3'b000};

	always_comb
	begin
		case (rop)
			rv_pkg::MEM_LB:  rdata = {{24{shifted[7]}}, shifted[7:0]};
			rv_pkg::MEM_LBU: rdata = {24'b0, shifted[7:0]};
			rv_pkg::MEM_LH:  rdata = {{16{shifted[15]}}, shifted[15:0]};
			rv_pkg::MEM_LHU: rdata = {16'b0, shifted[15:0]};
			rv_pkg::MEM_LW:  rdata = rword;
			default:         rdata = '0;
		endcase
	end

endmodule

// ==== trap/kill_timer.sv ====
module kill_timer #(
	parameter int COUNT = 6
) (
	input  logic clk,
	input  logic nrst,
	input  logic start,
	output logic done
);

	localparam int W = $clog2(COUNT + 1);

	logic [W-1:0] cnt;
	logic         busy;

	assign busy = (cnt != '0);
	assign done = busy && (cnt == W'(COUNT - 1));

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			cnt <= '0;
		else if (start)
			cnt <= W'(1);   // start edge is the first flushed update
		else if (done)
			cnt <= '0;
		else if (busy)
			cnt <= cnt + 1'b1;
	end

	// trap_ctrl only restarts once the previous flush is over
	a_no_restart : assert property (@(posedge clk) disable iff (!nrst)
		start |-> !busy);

endmodule

// ==== trap/trap_ctrl.sv ====
module trap_ctrl #(
	parameter int KILL_CYCLES = 6
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  rv_pkg::exc_t            exc,
	input  logic [rv_pkg::xlen-1:0] pc6,
	input  rv_pkg::irq_t            irq,
	input  rv_pkg::mode_e           mode,
	output logic                    squash,
	output rv_pkg::trap_t           trap
);

	typedef enum logic {RUN, FLUSH} state_e;

	state_e                  state;
	logic                    m_timer_g;
	logic                    s_timer_g;
	logic                    m_ext_g;
	logic                    s_ext_g;
	logic                    irq_any;
	logic                    exc_any;
	logic                    pending;
	logic                    done;
	logic                    is_int;
	logic [rv_pkg::xlen-2:0] code;

	// supervisor interrupts are masked in machine mode
	assign m_timer_g = irq.m_tie && irq.m_timer;
	assign m_ext_g   = irq.m_eie && irq.m_ext;
	assign s_timer_g = (mode <= rv_pkg::MODE_S) && irq.s_tie && irq.s_timer;
	assign s_ext_g   = (mode <= rv_pkg::MODE_S) && irq.s_eie && irq.s_ext;

	assign irq_any = m_timer_g || s_timer_g || m_ext_g || s_ext_g;
	assign exc_any = exc.instr_misaligned || exc.ecall || exc.illegal || exc.mem_misaligned;
	assign pending = (state == RUN) && (irq_any || exc_any);

	always_comb
	begin
		is_int = 1'b1;
		code   = '0;
		if (m_ext_g)
			code = rv_pkg::M_INT_EXT;
		else if (s_ext_g)
			code = rv_pkg::S_INT_EXT;
		else if (m_timer_g)
			code = rv_pkg::M_INT_TIMER;
		else if (s_timer_g)
			code = rv_pkg::S_INT_TIMER;
		else
		begin
			is_int = 1'b0;
			if (exc.instr_misaligned)
				code = rv_pkg::I_ADDR_MISALIGNED;
			else if (exc.ecall)
				code = rv_pkg::U_CALL + 31'(mode);   // ecall cause depends on mode
			else if (exc.illegal)
				code = rv_pkg::I_ILLEGAL;
			else if (exc.mem_misaligned)
				code = rv_pkg::L_ADDR_MISALIGNED;   // loads and stores alike
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= RUN;
		else if (state == RUN && pending)
			state <= FLUSH;
		else if (state == FLUSH && done)
			state <= RUN;
	end

	kill_timer #(
		.COUNT (KILL_CYCLES)
	) i_kill_timer (
		.clk   (clk),
		.nrst  (nrst),
		.start (pending),
		.done  (done)
	);

	assign squash       = pending || (state == FLUSH);
	assign trap.pending = pending;
	assign trap.cause   = {is_int, code};
	assign trap.pc      = pc6;

	// instruction misaligned is the only cause encoded as zero
	a_cause_valid : assert property (@(posedge clk) disable iff (!nrst)
		trap.pending |-> (trap.cause != '0 || exc.instr_misaligned));

endmodule

// ==== verilog/exe_top.sv ====
module exe_top #(
	parameter int DMEM_WORDS  = 256,
	parameter int KILL_CYCLES = 6
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  rv_pkg::exe_req_t        req,
	input  rv_pkg::irq_t            irq,
	input  rv_pkg::mode_e           mode,
	output rv_pkg::wb_t             wb,
	output logic [rv_pkg::xlen-1:0] target,
	output logic                    bj_taken,
	output rv_pkg::trap_t           trap
);

	logic [rv_pkg::xlen-1:0] mem_addr;
	logic [rv_pkg::xlen-1:0] mem_wdata;
	logic [rv_pkg::xlen-1:0] mem_rdata;
	rv_pkg::mem_op_e         mem_op;
	logic                    mem_misaligned;
	rv_pkg::exc_t            exc;
	logic [rv_pkg::xlen-1:0] pc6;
	logic                    squash;

	exe_stage i_exe_stage (
		.clk            (clk),
		.nrst           (nrst),
		.req            (req),
		.squash         (squash),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_op         (mem_op),
		.mem_rdata      (mem_rdata),
		.mem_misaligned (mem_misaligned),
		.wb             (wb),
		.target         (target),
		.bj_taken       (bj_taken),
		.exc            (exc),
		.pc6            (pc6)
	);

	dmem #(
		.DMEM_WORDS (DMEM_WORDS)
	) i_dmem (
		.clk        (clk),
		.nrst       (nrst),
		.op         (mem_op),
		.addr       (mem_addr),
		.wdata      (mem_wdata),
		.rdata      (mem_rdata),
		.misaligned (mem_misaligned)
	);

	trap_ctrl #(
		.KILL_CYCLES (KILL_CYCLES)
	) i_trap_ctrl (
		.clk    (clk),
		.nrst   (nrst),
		.exc    (exc),
		.pc6    (pc6),
		.irq    (irq),
		.mode   (mode),
		.squash (squash),
		.trap   (trap)
	);

endmodule

// ==== bench/tb_exe_top.sv ====
module tb_exe_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DMEM_WORDS  = 256;
	localparam int KILL_CYCLES = 6;
	localparam int N_REQS      = 3000;

	// expected pipe 6 contents
	typedef struct packed {
		rv_pkg::wb_t     wb;
		rv_pkg::exc_t    exc;
		logic [31:0]     pc;
	} stage_t;

	logic             clk;
	logic             nrst;
	rv_pkg::exe_req_t req;
	rv_pkg::irq_t     irq;
	rv_pkg::mode_e    mode;
	rv_pkg::wb_t      wb;
	logic [31:0]      target;
	logic             bj_taken;
	rv_pkg::trap_t    trap;

	logic [31:0] lfsr;
	logic [31:0] shadow [DMEM_WORDS];
	stage_t      s5;
	stage_t      s6;
	int          flush_left;
	int          n_traps;
	int          n_loads;
	int          n_mis;
	int          drain_cnt;

	exe_top #(
		.DMEM_WORDS  (DMEM_WORDS),
		.KILL_CYCLES (KILL_CYCLES)
	) i_exe_top (
		.clk      (clk),
		.nrst     (nrst),
		.req      (req),
		.irq      (irq),
		.mode     (mode),
		.wb       (wb),
		.target   (target),
		.bj_taken (bj_taken),
		.trap     (trap)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_wb(input rv_pkg::wb_t got, input rv_pkg::wb_t exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED t=%0t wb got %h/%0d/%b expected %h/%0d/%b", $time,
				got.data, got.rd, got.we, exp.data, exp.rd, exp.we));
	endtask

	task automatic check_trap(input rv_pkg::trap_t got, input rv_pkg::trap_t exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED t=%0t trap got %b/%h/%h expected %b/%h/%h", $time,
				got.pending, got.cause, got.pc, exp.pending, exp.cause, exp.pc));
	endtask

	task automatic check_target(input logic [31:0] got_t, input logic got_k,
		input logic [31:0] exp_t, input logic exp_k);
		if (got_t !== exp_t)
			fail_now($sformatf("CHECK FAILED t=%0t target got %h expected %h", $time, got_t, exp_t));
		if (got_k !== exp_k)
			fail_now($sformatf("CHECK FAILED t=%0t bj_taken got %b expected %b", $time, got_k, exp_k));
	endtask

	function automatic logic [31:0] alu_model(rv_pkg::alu_op_e fn, logic [31:0] a, logic [31:0] b);
		logic [31:0] r;
		case (fn)
			rv_pkg::ALU_ADD:  r = a + b;
			rv_pkg::ALU_SUB:  r = a - b;
			rv_pkg::ALU_SLL:  r = a << b[4:0];
			rv_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rv_pkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
			rv_pkg::ALU_XOR:  r = a ^ b;
			rv_pkg::ALU_SRL:  r = a >> b[4:0];
			rv_pkg::ALU_SRA:  r = $signed(a) >>> b[4:0];
			rv_pkg::ALU_OR:   r = a | b;
			rv_pkg::ALU_AND:  r = a & b;
			default:          r = '0;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] mul_model(rv_pkg::mul_op_e op, logic [31:0] a, logic [31:0] b);
		longint      pa;
		longint      pb;
		logic [63:0] p;
		pa = (op == rv_pkg::MUL_MULH || op == rv_pkg::MUL_MULHSU) ? longint'($signed(a))
			: longint'({32'b0, a});
		pb = (op == rv_pkg::MUL_MULH) ? longint'($signed(b)) : longint'({32'b0, b});
		p  = pa * pb;   // low 64 bits are right for every signedness
		return (op == rv_pkg::MUL_MUL) ? p[31:0] : p[63:32];
	endfunction

	function automatic logic [31:0] load_model(rv_pkg::mem_op_e op, logic [31:0] w, logic [1:0] off);
		logic [31:0] sh;
		sh = w >> (8 * off);
		case (op)
			rv_pkg::MEM_LB:  return {{24{sh[7]}}, sh[7:0]};
			rv_pkg::MEM_LBU: return {24'b0, sh[7:0]};
			rv_pkg::MEM_LH:  return {{16{sh[15]}}, sh[15:0]};
			rv_pkg::MEM_LHU: return {16'b0, sh[15:0]};
			rv_pkg::MEM_LW:  return w;
			default:         return '0;
		endcase
	endfunction

	task automatic branch_model(input rv_pkg::exe_req_t r, output logic [31:0] t, output logic k);
		logic cond;
		logic bt;
		if (r.alu_fn == rv_pkg::ALU_SLT)
			cond = $signed(r.op_a) < $signed(r.op_b);
		else if (r.alu_fn == rv_pkg::ALU_SLTU)
			cond = r.op_a < r.op_b;
		else
			cond = r.op_a == r.op_b;
		bt = r.btype & (cond ^ r.bneq);
		if (r.jr)
			t = (r.op_a + r.op_b) & ~32'd1;
		else if (r.j)
			t = r.pc + r.j_imm;
		else if (bt)
			t = r.pc + r.b_imm;
		else
			t = r.pc + 32'd4;
		k = bt | r.j | r.jr;
	endtask

	// {m_ext, s_ext, m_timer, s_timer} after enables and mode
	function automatic logic [3:0] irq_gated(rv_pkg::irq_t q, rv_pkg::mode_e m);
		logic s_ok;
		s_ok = (m != rv_pkg::MODE_M);
		return {q.m_ext & q.m_eie, q.s_ext & q.s_eie & s_ok,
			q.m_timer & q.m_tie, q.s_timer & q.s_tie & s_ok};
	endfunction

	function automatic logic [31:0] cause_model(rv_pkg::exc_t e, rv_pkg::irq_t q, rv_pkg::mode_e m);
		logic [3:0] g;
		g = irq_gated(q, m);
		if (g[3])
			return {1'b1, rv_pkg::M_INT_EXT};
		if (g[2])
			return {1'b1, rv_pkg::S_INT_EXT};
		if (g[1])
			return {1'b1, rv_pkg::M_INT_TIMER};
		if (g[0])
			return {1'b1, rv_pkg::S_INT_TIMER};
		if (e.instr_misaligned)
			return {1'b0, rv_pkg::I_ADDR_MISALIGNED};
		if (e.ecall)
			return {1'b0, rv_pkg::U_CALL + 31'(m)};
		if (e.illegal)
			return {1'b0, rv_pkg::I_ILLEGAL};
		if (e.mem_misaligned)
			return {1'b0, rv_pkg::L_ADDR_MISALIGNED};
		return '0;
	endfunction

	task automatic make_req(input logic bubble, output rv_pkg::exe_req_t r,
		output rv_pkg::irq_t q, output rv_pkg::mode_e m, output stage_t e);
		logic [2:0]  kind;
		logic [1:0]  w;
		logic [1:0]  sel;
		logic [31:0] addr;
		logic [31:0] off;
		logic [31:0] ld;
		logic        mis;
		logic        is_store;
		int          idx;
		r        = '0;
		r.op_a   = rand_bits(32);
		r.op_b   = rand_bits(32);
		r.pc     = {30'(rand_bits(30)), 2'b00};
		r.b_imm  = rand_bits(32);
		r.j_imm  = rand_bits(32);
		r.u_imm  = {20'(rand_bits(20)), 12'b0};
		r.s_imm  = rand_bits(32);
		r.rd     = rand_bits(5);
		r.alu_fn = rv_pkg::alu_op_e'(4'(rand_bits(4) % 10));
		r.mul_op = rv_pkg::mul_op_e'(rand_bits(2));
		r.btype  = rand_bits(1);
		r.bneq   = rand_bits(1);
		r.j      = (rand_bits(3) == 0);
		r.jr     = (rand_bits(3) == 0);
		if (rand_bits(2) == 0)
			r.op_b = r.op_a;   // gives beq a chance
		r.instr_misaligned = (rand_bits(6) == 0);
		r.ecall            = (rand_bits(6) == 0);
		r.illegal          = (rand_bits(6) == 0);
		q         = '0;
		q.m_timer = (rand_bits(6) == 0);
		q.s_timer = (rand_bits(6) == 0);
		q.m_ext   = (rand_bits(6) == 0);
		q.s_ext   = (rand_bits(6) == 0);
		{q.m_tie, q.s_tie, q.m_eie, q.s_eie} = rand_bits(4);
		sel = rand_bits(2);
		m   = (sel == 2'd0) ? rv_pkg::MODE_U : (sel == 2'd1) ? rv_pkg::MODE_S : rv_pkg::MODE_M;
		kind = rand_bits(3);
		case (kind)
			3'd0, 3'd1, 3'd2: r.we = 1'b1;
			3'd3:
			begin
				r.wb_sel = rv_pkg::WB_MUL;
				r.we     = 1'b1;
			end
			3'd4:
			begin
				sel      = rand_bits(2);
				r.wb_sel = (sel == 2'd0) ? rv_pkg::WB_LUI
					: (sel == 2'd1) ? rv_pkg::WB_AUIPC : rv_pkg::WB_PC4;
				r.we     = 1'b1;
			end
			3'd5, 3'd6:
			begin
				w    = rand_bits(2);
				addr = {26'b0, 4'(rand_bits(4)), 2'b00};   // 16 words so loads hit stores
				if (w == 2'd0)
					addr[1:0] = rand_bits(2);
				else if (w == 2'd1)
					addr[1] = rand_bits(1);
				if (rand_bits(4) == 0 && w != 2'd0)
					addr[0] = 1'b1;
				off    = rand_bits(4);
				r.op_a = addr - off;
				if (kind == 3'd5)
				begin
					r.s_imm  = off;
					r.mem_op = (w == 2'd0) ? rv_pkg::MEM_SB
						: (w == 2'd1) ? rv_pkg::MEM_SH : rv_pkg::MEM_SW;
				end
				else
				begin
					r.op_b   = off;
					r.wb_sel = rv_pkg::WB_MEM;
					r.we     = 1'b1;
					if (w == 2'd0)
						r.mem_op = rand_bits(1) ? rv_pkg::MEM_LB : rv_pkg::MEM_LBU;
					else if (w == 2'd1)
						r.mem_op = rand_bits(1) ? rv_pkg::MEM_LH : rv_pkg::MEM_LHU;
					else
						r.mem_op = rv_pkg::MEM_LW;
				end
			end
			default: r.we = 1'b0;
		endcase
		if (bubble)
		begin
			r = '0;
			q = '0;
		end

		// shadow memory is read before this request's own store
		is_store = r.mem_op inside {rv_pkg::MEM_SB, rv_pkg::MEM_SH, rv_pkg::MEM_SW};
		addr     = r.op_a + (is_store ? r.s_imm : r.op_b);
		idx      = int'((addr >> 2) % DMEM_WORDS);
		mis      = (r.mem_op inside {rv_pkg::MEM_LH, rv_pkg::MEM_LHU, rv_pkg::MEM_SH} && addr[0])
			|| (r.mem_op inside {rv_pkg::MEM_LW, rv_pkg::MEM_SW} && addr[1:0] != 2'b00);
		ld       = load_model(r.mem_op, shadow[idx], addr[1:0]);
		if (!mis)
		begin
			case (r.mem_op)
				rv_pkg::MEM_SB: shadow[idx][8 * addr[1:0] +: 8]  = r.op_b[7:0];
				rv_pkg::MEM_SH: shadow[idx][8 * addr[1:0] +: 16] = r.op_b[15:0];
				rv_pkg::MEM_SW: shadow[idx] = r.op_b;
				default: ;
			endcase
		end
		if (mis)
			n_mis++;
		else if (r.wb_sel == rv_pkg::WB_MEM)
			n_loads++;

		e = '0;
		case (r.wb_sel)
			rv_pkg::WB_ALU:   e.wb.data = alu_model(r.alu_fn, r.op_a, r.op_b);
			rv_pkg::WB_PC4:   e.wb.data = r.pc + 32'd4;
			rv_pkg::WB_MUL:   e.wb.data = mul_model(r.mul_op, r.op_a, r.op_b);
			rv_pkg::WB_LUI:   e.wb.data = r.u_imm;
			rv_pkg::WB_MEM:   e.wb.data = ld;
			rv_pkg::WB_AUIPC: e.wb.data = r.u_imm + r.pc;
			default:          e.wb.data = '0;
		endcase
		e.wb.rd                 = r.rd;
		e.wb.we                 = r.we;
		e.pc                    = r.pc;
		e.exc.instr_misaligned  = r.instr_misaligned;
		e.exc.ecall             = r.ecall;
		e.exc.illegal           = r.illegal;
		e.exc.mem_misaligned    = mis;
	endtask

	// drive on the falling edge and check, then advance the model past the rising edge
	task automatic run_cycle(input logic bubble);
		rv_pkg::exe_req_t r;
		rv_pkg::irq_t     q;
		rv_pkg::mode_e    m;
		stage_t           nxt;
		rv_pkg::trap_t    exp_trap;
		logic [31:0]      exp_t;
		logic             exp_k;
		make_req(bubble, r, q, m, nxt);
		req  = r;
		irq  = q;
		mode = m;
		#1;
		branch_model(r, exp_t, exp_k);
		check_target(target, bj_taken, exp_t, exp_k);
		check_wb(wb, s6.wb);
		exp_trap.pending = (flush_left == 0) && (s6.exc != '0 || irq_gated(q, m) != '0);
		exp_trap.cause   = cause_model(s6.exc, q, m);
		exp_trap.pc      = s6.pc;
		check_trap(trap, exp_trap);
		if (exp_trap.pending)
		begin
			n_traps++;
			flush_left = KILL_CYCLES - 1;   // pending edge is the first squash
			s6         = '0;
		end
		else if (flush_left != 0)
		begin
			flush_left--;
			s6 = '0;
		end
		else
			s6 = s5;
		s5 = nxt;
		@(negedge clk);
	endtask

	initial
	begin
		lfsr       = 32'hf7ef9c7b;
		nrst       = 1'b0;
		req        = '0;
		irq        = '0;
		mode       = rv_pkg::MODE_U;
		s5         = '0;
		s6         = '0;
		flush_left = 0;
		n_traps    = 0;
		n_loads    = 0;
		n_mis      = 0;
		drain_cnt  = 0;
		for (int i = 0; i < DMEM_WORDS; i++)
			shadow[i] = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;

		for (int n = 0; n < N_REQS; n++)
			run_cycle(1'b0);

		// bubbles until the flush is over and the pipe is empty
		while (flush_left != 0 || s5 != '0 || s6 != '0)
		begin
			run_cycle(1'b1);
			drain_cnt++;
			if (drain_cnt > 4 * KILL_CYCLES)
				fail_now("pipeline did not drain after the last request");
		end

		if (n_traps == 0 || n_loads == 0 || n_mis == 0)
			fail_now("random stimulus produced no trap, no aligned load or no misaligned access");
		else
		begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// ==== exe_top.f ====
common/rv_pkg.sv
exe_stage/alu.sv
exe_stage/branch_unit.sv
exe_stage/mul_div.sv
exe_stage/exe_stage.sv
verilog/dmem.sv
trap/kill_timer.sv
trap/trap_ctrl.sv
verilog/exe_top.sv
bench/tb_exe_top.sv

// ==== Bender.yml ====
package:
  name: exe_top

sources:
  - common/rv_pkg.sv
  - exe_stage/alu.sv
  - exe_stage/branch_unit.sv
  - exe_stage/mul_div.sv
  - exe_stage/exe_stage.sv
  - verilog/dmem.sv
  - trap/kill_timer.sv
  - trap/trap_ctrl.sv
  - verilog/exe_top.sv
  - target: test
    files:
      - bench/tb_exe_top.sv
